//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Program counter value loaded by arst_n
`define CPU_RESET_PC 16'h0200

// NOP encoding, also the opcode held while in reset
`define CPU_NOP_OPCODE 8'hEA

`endif

//--- common/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [7:0] {
        OP_ASL_A   = 8'h0A,
        OP_ASL_ZPG = 8'h06,
        OP_ASL_ZPX = 8'h16,
        OP_ASL_ABS = 8'h0E,
        OP_LSR_A   = 8'h4A,
        OP_LSR_ZPG = 8'h46,
        OP_LSR_ZPX = 8'h56,
        OP_LSR_ABS = 8'h4E,
        OP_ROL_A   = 8'h2A,
        OP_ROL_ZPG = 8'h26,
        OP_ROL_ZPX = 8'h36,
        OP_ROL_ABS = 8'h2E,
        OP_ROR_A   = 8'h6A,
        OP_ROR_ZPG = 8'h66,
        OP_ROR_ZPX = 8'h76,
        OP_ROR_ABS = 8'h6E,
        OP_LDA_IMM = 8'hA9,
        OP_LDX_IMM = 8'hA2,
        OP_SEC     = 8'h38,
        OP_CLC     = 8'h18,
        OP_NOP     = `CPU_NOP_OPCODE
    } opcode_t;

    // Shift group takes its mode straight from opcode bits 4:2
    typedef enum logic [2:0] {
        MODE_IMM   = 3'b000,
        MODE_ZPG   = 3'b001,
        MODE_ACC   = 3'b010,
        MODE_ABS   = 3'b011,
        MODE_ZPG_X = 3'b101
    } addr_mode_t;

    typedef enum logic [2:0] {
        S_FETCH, S_EXEC, S_ADR_LO, S_ADR_HI, S_INDEX, S_READ, S_MODIFY, S_WRITE
    } decode_state_t;

    typedef enum logic [2:0] {
        ALU_NONE, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_LDA, ALU_LDX, ALU_SETC
    } alu_op_t;

    typedef enum logic {
        ADDR_PC, ADDR_EA
    } addr_sel_t;

endpackage

`default_nettype wire

//--- decode/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instruction_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rdy,
    input  logic [7:0]          data_in,
    output logic                sync,
    output logic                pc_inc,
    output logic                ea_lo_load,
    output logic                ea_hi_load,
    output logic                ea_index_add,
    output logic                latch_load,
    output logic                mem_write,
    output logic                alu_to_mem,
    output cpu_pkg::addr_sel_t  addr_sel,
    output cpu_pkg::alu_op_t    alu_op
);
    import cpu_pkg::*;

    decode_state_t state;
    decode_state_t state_nxt;
    logic [7:0]    opcode_q;
    logic [7:0]    op_now;
    addr_mode_t    mode;
    alu_op_t       ins_alu;

    // Opcode is on data_in during fetch, held in opcode_q afterwards
    always_comb begin
        op_now  = (state == S_FETCH) ? data_in : opcode_q;
        mode    = MODE_ACC; // Implied and unknown run like accumulator ops
        ins_alu = ALU_NONE;
        case (op_now)
            OP_ASL_A, OP_ASL_ZPG, OP_ASL_ZPX, OP_ASL_ABS: begin
                mode    = addr_mode_t'(op_now[4:2]);
                ins_alu = ALU_ASL;
            end
            OP_LSR_A, OP_LSR_ZPG, OP_LSR_ZPX, OP_LSR_ABS: begin
                mode    = addr_mode_t'(op_now[4:2]);
                ins_alu = ALU_LSR;
            end
            OP_ROL_A, OP_ROL_ZPG, OP_ROL_ZPX, OP_ROL_ABS: begin
                mode    = addr_mode_t'(op_now[4:2]);
                ins_alu = ALU_ROL;
            end
            OP_ROR_A, OP_ROR_ZPG, OP_ROR_ZPX, OP_ROR_ABS: begin
                mode    = addr_mode_t'(op_now[4:2]);
                ins_alu = ALU_ROR;
            end
            OP_LDA_IMM: begin
                mode    = MODE_IMM;
                ins_alu = ALU_LDA;
            end
            OP_LDX_IMM: begin
                mode    = MODE_IMM;
                ins_alu = ALU_LDX;
            end
            OP_SEC, OP_CLC: ins_alu = ALU_SETC; // Carry value comes from opcode bit 5
            OP_NOP:         ins_alu = ALU_NONE;
            default:        ins_alu = ALU_NONE;
        endcase
    end

    always_comb begin
        state_nxt    = state;
        sync         = 1'b0;
        pc_inc       = 1'b0;
        ea_lo_load   = 1'b0;
        ea_hi_load   = 1'b0;
        ea_index_add = 1'b0;
        latch_load   = 1'b0;
        mem_write    = 1'b0;
        alu_to_mem   = 1'b0;
        addr_sel     = ADDR_PC;
        alu_op       = ALU_NONE;
        case (state)
            S_FETCH: begin
                sync       = rdy; // Low while stalled
                pc_inc     = 1'b1;
                latch_load = 1'b1; // Opcode kept for SEC/CLC
                if (mode inside {MODE_ZPG, MODE_ZPG_X, MODE_ABS})
                    state_nxt = S_ADR_LO;
                else
                    state_nxt = S_EXEC;
            end
            S_EXEC: begin
                alu_op    = ins_alu;
                pc_inc    = (mode == MODE_IMM); // Step over the immediate byte
                state_nxt = S_FETCH;
            end
            S_ADR_LO: begin
                pc_inc     = 1'b1;
                ea_lo_load = 1'b1;
                case (mode)
                    MODE_ZPG:   state_nxt = S_READ;
                    MODE_ZPG_X: state_nxt = S_INDEX;
                    default:    state_nxt = S_ADR_HI;
                endcase
            end
            S_ADR_HI: begin
                pc_inc     = 1'b1;
                ea_hi_load = 1'b1;
                state_nxt  = S_READ;
            end
            S_INDEX: begin
                addr_sel     = ADDR_EA; // Dummy read of the unindexed byte
                ea_index_add = 1'b1;
                state_nxt    = S_READ;
            end
            S_READ: begin
                addr_sel   = ADDR_EA;
                latch_load = 1'b1;
                state_nxt  = S_MODIFY;
            end
            S_MODIFY: begin
                addr_sel   = ADDR_EA;
                alu_op     = ins_alu;
                alu_to_mem = 1'b1;
                state_nxt  = S_WRITE;
            end
            S_WRITE: begin
                addr_sel  = ADDR_EA;
                mem_write = 1'b1;
                state_nxt = S_FETCH;
            end
            default: state_nxt = S_FETCH;
        endcase
    end

    // Reset parks in S_EXEC on a NOP so the first fetch follows one edge later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_EXEC;
            opcode_q <= `CPU_NOP_OPCODE;
        end else if (rdy) begin
            state <= state_nxt;
            if (state == S_FETCH)
                opcode_q <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/address_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module address_unit (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic        pc_inc,
    input  logic        ea_lo_load,
    input  logic        ea_hi_load,
    input  logic        ea_index_add,
    input  logic [7:0]  data_in,
    input  logic [7:0]  x,
    output logic [15:0] pc,
    output logic [15:0] ea
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (rdy && pc_inc) begin
            pc <= pc + 16'd1;
        end
    end

    // Effective address built byte by byte from the instruction stream
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (ea_lo_load) begin
                ea <= {8'h00, data_in}; // Zero page until a high byte arrives
            end else if (ea_hi_load) begin
                ea[15:8] <= data_in;
            end else if (ea_index_add) begin
                ea[7:0] <= ea[7:0] + x; // Wraps within page zero
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module bus_interface (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rdy,
    input  logic               latch_load,
    input  logic               mem_write,
    input  cpu_pkg::addr_sel_t addr_sel,
    input  logic [15:0]        pc,
    input  logic [15:0]        ea,
    input  logic [7:0]         data_in,
    input  logic [7:0]         result,
    output logic [15:0]        addr,
    output logic [7:0]         data_out,
    output logic [7:0]         data_latch,
    output logic               we
);
    import cpu_pkg::*;

    // Input data latch, holds the opcode or the memory operand
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_latch <= 8'h00;
        end else if (rdy && latch_load) begin
            data_latch <= data_in;
        end
    end

    assign addr     = (addr_sel == ADDR_EA) ? ea : pc;
    assign data_out = result;
    assign we       = mem_write & rdy; // No write while stalled

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic [15:0] addr,
    output logic [7:0]  data_out,
    output logic [7:0]  acc,
    output logic [7:0]  x,
    output logic        we,
    output logic        sync,
    output logic        flag_n,
    output logic        flag_z,
    output logic        flag_c
);
    import cpu_pkg::*;

    logic        pc_inc;
    logic        ea_lo_load;
    logic        ea_hi_load;
    logic        ea_index_add;
    logic        latch_load;
    logic        mem_write;
    logic        alu_to_mem;
    addr_sel_t   addr_sel;
    alu_op_t     alu_op;
    logic [15:0] pc;
    logic [15:0] ea;
    logic [7:0]  result;
    logic [7:0]  data_latch;

    instruction_decode i_decode (
        .clk, .arst_n, .rdy, .data_in,
        .sync, .pc_inc, .ea_lo_load, .ea_hi_load, .ea_index_add,
        .latch_load, .mem_write, .alu_to_mem, .addr_sel, .alu_op
    );

    address_unit i_address (
        .clk, .arst_n, .rdy, .pc_inc, .ea_lo_load, .ea_hi_load, .ea_index_add,
        .data_in, .x, .pc, .ea
    );

    shift_alu i_alu (
        .clk, .arst_n, .rdy, .alu_to_mem, .alu_op,
        .operand (data_latch), // Memory byte or latched opcode
        .imm     (data_in),    // Immediate byte read at pc
        .acc, .x, .result, .flag_n, .flag_z, .flag_c
    );

    bus_interface i_bus (
        .clk, .arst_n, .rdy, .latch_load, .mem_write, .addr_sel,
        .pc, .ea, .data_in, .result, .addr, .data_out, .data_latch, .we
    );

endmodule

`default_nettype wire

//--- logic/shift_alu.sv
`timescale 1ns/1ps
`default_nettype none

module shift_alu (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             rdy,
    input  logic             alu_to_mem,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic [7:0]       operand,
    input  logic [7:0]       imm,
    output logic [7:0]       acc,
    output logic [7:0]       x,
    output logic [7:0]       result,
    output logic             flag_n,
    output logic             flag_z,
    output logic             flag_c
);
    import cpu_pkg::*;

    logic [7:0] src;
    logic [7:0] shifted;
    logic       carry_out;
    logic       is_shift;

    assign src      = alu_to_mem ? operand : acc; // Memory byte or accumulator
    assign is_shift = alu_op inside {ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR};

    always_comb begin
        shifted   = src;
        carry_out = flag_c;
        case (alu_op)
            ALU_ASL: {carry_out, shifted} = {src, 1'b0};
            ALU_LSR: {shifted, carry_out} = {1'b0, src};
            ALU_ROL: {carry_out, shifted} = {src, flag_c}; // Rotate through carry
            ALU_ROR: {shifted, carry_out} = {flag_c, src};
            default: shifted = src;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= 8'h00;
            x      <= 8'h00;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (rdy) begin
            case (alu_op)
                ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR: begin
                    if (!alu_to_mem)
                        acc <= shifted;
                    flag_n <= shifted[7];
                    flag_z <= (shifted == 8'h00);
                    flag_c <= carry_out;
                end
                ALU_LDA: begin
                    acc    <= imm;
                    flag_n <= imm[7];
                    flag_z <= (imm == 8'h00);
                end
                ALU_LDX: begin
                    x      <= imm;
                    flag_n <= imm[7];
                    flag_z <= (imm == 8'h00);
                end
                ALU_SETC: flag_c <= operand[5]; // Latched opcode, SEC vs CLC
                default: ;
            endcase
        end
    end

    // Held until the write cycle
    always_ff @(posedge clk) begin
        if (rdy && is_shift && alu_to_mem)
            result <= shifted;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/cpu_pkg.sv
decode/instruction_decode.sv
logic/address_unit.sv
logic/shift_alu.sv
logic/bus_interface.sv
logic/cpu_core.sv
test/tb_cpu_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

output=$(verilator --binary --timing -f project.f --top-module tb_cpu_core 2>&1 &&
         ./obj_dir/Vtb_cpu_core 2>&1)
echo "$output"

echo "$output" | grep -qx "Everything OK" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

//--- test/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_core;

    logic        clk;
    logic        arst_n;
    logic        rdy;
    logic [7:0]  data_in;
    logic [15:0] addr;
    logic [7:0]  data_out;
    logic [7:0]  acc;
    logic [7:0]  x;
    logic        we;
    logic        sync;
    logic        flag_n;
    logic        flag_z;
    logic        flag_c;

    logic [7:0]  mem [0:65535];
    logic [15:0] code_ptr;     // Next free program byte
    logic        stalls_on;
    integer      seed;
    int          sync_seen;
    int          writes_seen;
    logic [15:0] last_wr_addr;
    logic [7:0]  last_wr_data;
    int          checks;
    int          errors;

    logic [7:0]  tab_a [$];
    logic [7:0]  tab_x [$];
    logic        tab_c [$];
    logic [7:0]  tab_op [$];
    logic [15:0] tab_opnd [$];  // Operand bytes, low byte first in memory
    logic [7:0]  tab_mem [$];   // Byte placed at the target before the run
    logic [7:0]  tab_acc [$];
    logic [2:0]  tab_nzc [$];
    logic [15:0] tab_waddr [$]; // Zero when no write is expected
    logic [7:0]  tab_wdata [$];

    cpu_core i_dut (
        .clk, .arst_n, .rdy, .data_in, .addr, .data_out, .acc, .x,
        .we, .sync, .flag_n, .flag_z, .flag_c
    );

    assign data_in = mem[addr]; // Combinational read

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error at %0t: %0s expected %h got %h", $time, what, exp, got);
        end
    endtask

    // Samples the bus at the edge, then updates memory and rdy 1 ns later
    task automatic next_cycle();
        logic        wr_pending;
        logic [15:0] wr_addr;
        logic [7:0]  wr_data;
        logic [31:0] rnd;
        @(posedge clk);
        if (!arst_n) begin
            check_value("sync during reset", 16'(sync), 16'h0000);
            check_value("we during reset", 16'(we), 16'h0000);
        end
        if (sync && sync_seen == 0)
            check_value("first fetch address", addr, `CPU_RESET_PC);
        if (sync)
            sync_seen = sync_seen + 1;
        if (we)
            check_value("rdy during write", 16'(rdy), 16'h0001);
        wr_pending = we;
        wr_addr    = addr;
        wr_data    = data_out;
        #1;
        if (wr_pending) begin
            mem[wr_addr] = wr_data;
            writes_seen  = writes_seen + 1;
            last_wr_addr = wr_addr;
            last_wr_data = wr_data;
        end
        rnd = $random(seed);
        rdy = stalls_on ? (rnd[1:0] != 2'b00) : 1'b1; // About one stall in four
    endtask

    task automatic wait_for_syncs(input int target, input int idx, output logic reached);
        int cycles;
        cycles = 0;
        while (sync_seen < target && cycles < 200) begin
            next_cycle();
            cycles = cycles + 1;
        end
        reached = (sync_seen >= target);
        if (!reached)
            $display("timeout: case %0d never reached its closing NOP fetch", idx);
    endtask

    task automatic add_case(input logic [7:0] a, input logic [7:0] xv, input logic c,
                            input logic [7:0] op, input logic [15:0] opnd,
                            input logic [7:0] mem_b, input logic [7:0] exp_acc,
                            input logic [2:0] nzc, input logic [15:0] waddr,
                            input logic [7:0] wdata);
        tab_a.push_back(a);
        tab_x.push_back(xv);
        tab_c.push_back(c);
        tab_op.push_back(op);
        tab_opnd.push_back(opnd);
        tab_mem.push_back(mem_b);
        tab_acc.push_back(exp_acc);
        tab_nzc.push_back(nzc);
        tab_waddr.push_back(waddr);
        tab_wdata.push_back(wdata);
    endtask

    function automatic int instr_len(input logic [7:0] op);
        if (op == 8'hA9 || op == 8'hA2)
            return 2;
        case (op[3:0])
            4'h6:    return 2; // Zero page and zero page X
            4'hE:    return 3; // Absolute
            default: return 1;
        endcase
    endfunction

    task automatic put_byte(input logic [7:0] b);
        mem[code_ptr] = b;
        code_ptr      = code_ptr + 16'd1;
    endtask

    // LDA #a, LDX #x, SEC or CLC, the tested opcode, NOP
    task automatic load_case(input int i);
        int len;
        len = instr_len(tab_op[i]);
        put_byte(8'hA9);
        put_byte(tab_a[i]);
        put_byte(8'hA2);
        put_byte(tab_x[i]);
        put_byte(tab_c[i] ? 8'h38 : 8'h18);
        put_byte(tab_op[i]);
        if (len >= 2)
            put_byte(tab_opnd[i][7:0]);
        if (len == 3)
            put_byte(tab_opnd[i][15:8]);
        put_byte(8'hEA);
        if (tab_waddr[i] != 16'h0000)
            mem[tab_waddr[i]] = tab_mem[i];
    endtask

    task automatic check_case(input int i);
        logic [7:0] exp_x;
        logic       exp_write;
        exp_x     = (tab_op[i] == 8'hA2) ? tab_opnd[i][7:0] : tab_x[i]; // LDX replaces X
        exp_write = (tab_waddr[i] != 16'h0000);
        check_value("acc", 16'(acc), 16'(tab_acc[i]));
        check_value("x", 16'(x), 16'(exp_x));
        check_value("flags nzc", 16'({flag_n, flag_z, flag_c}), 16'(tab_nzc[i]));
        check_value("write count", 16'(writes_seen), 16'(exp_write));
        if (exp_write) begin
            check_value("write address", last_wr_addr, tab_waddr[i]);
            check_value("write data", 16'(last_wr_data), 16'(tab_wdata[i]));
            check_value("memory byte", 16'(mem[tab_waddr[i]]), 16'(tab_wdata[i]));
        end
    endtask

    initial begin
        int   round;
        int   i;
        int   err_before;
        int   cases_run;
        logic reached;
        arst_n      = 1'b1;
        rdy         = 1'b1;
        stalls_on   = 1'b0;
        seed        = 32'h467bb98a;
        sync_seen   = 0;
        writes_seen = 0;
        checks      = 0;
        errors      = 0;
        cases_run   = 0;
        code_ptr    = `CPU_RESET_PC;
        for (int k = 0; k < 65536; k++)
            mem[k[15:0]] = k[15:8] ^ k[7:0] ^ 8'h5A;

        // Accumulator shifts with carry in 0 and 1
        add_case(8'h81, 8'h00, 1'b0, 8'h0A, 16'h0000, 8'h00, 8'h02, 3'b001, 16'h0000, 8'h00);
        add_case(8'h40, 8'h3C, 1'b1, 8'h0A, 16'h0000, 8'h00, 8'h80, 3'b100, 16'h0000, 8'h00);
        add_case(8'h01, 8'h00, 1'b0, 8'h4A, 16'h0000, 8'h00, 8'h00, 3'b011, 16'h0000, 8'h00);
        add_case(8'hFE, 8'h3C, 1'b1, 8'h4A, 16'h0000, 8'h00, 8'h7F, 3'b000, 16'h0000, 8'h00);
        add_case(8'h80, 8'h00, 1'b0, 8'h2A, 16'h0000, 8'h00, 8'h00, 3'b011, 16'h0000, 8'h00);
        add_case(8'h55, 8'h3C, 1'b1, 8'h2A, 16'h0000, 8'h00, 8'hAB, 3'b100, 16'h0000, 8'h00);
        add_case(8'h01, 8'h00, 1'b0, 8'h6A, 16'h0000, 8'h00, 8'h00, 3'b011, 16'h0000, 8'h00);
        add_case(8'h02, 8'h3C, 1'b1, 8'h6A, 16'h0000, 8'h00, 8'h81, 3'b100, 16'h0000, 8'h00);
        // Zero page
        add_case(8'h33, 8'h00, 1'b0, 8'h06, 16'h0010, 8'hC3, 8'h33, 3'b101, 16'h0010, 8'h86);
        add_case(8'h5A, 8'h00, 1'b1, 8'h46, 16'h0020, 8'h81, 8'h5A, 3'b001, 16'h0020, 8'h40);
        add_case(8'h11, 8'h00, 1'b1, 8'h26, 16'h0030, 8'h7F, 8'h11, 3'b100, 16'h0030, 8'hFF);
        add_case(8'h22, 8'h00, 1'b0, 8'h66, 16'h00FF, 8'h01, 8'h22, 3'b011, 16'h00FF, 8'h00);
        // Zero page X, the last three wrap within page zero
        add_case(8'h44, 8'h05, 1'b0, 8'h16, 16'h0040, 8'h01, 8'h44, 3'b000, 16'h0045, 8'h02);
        add_case(8'h55, 8'h20, 1'b0, 8'h56, 16'h00F0, 8'h02, 8'h55, 3'b000, 16'h0010, 8'h01);
        add_case(8'h66, 8'hFF, 1'b1, 8'h36, 16'h0081, 8'h00, 8'h66, 3'b000, 16'h0080, 8'h01);
        add_case(8'h77, 8'h02, 1'b1, 8'h76, 16'h00FF, 8'h80, 8'h77, 3'b100, 16'h0001, 8'hC0);
        // Absolute
        add_case(8'h88, 8'h00, 1'b1, 8'h0E, 16'h1234, 8'h80, 8'h88, 3'b011, 16'h1234, 8'h00);
        add_case(8'h99, 8'h01, 1'b0, 8'h4E, 16'h8001, 8'hFF, 8'h99, 3'b001, 16'h8001, 8'h7F);
        add_case(8'hAA, 8'h00, 1'b0, 8'h2E, 16'h3456, 8'h40, 8'hAA, 3'b100, 16'h3456, 8'h80);
        add_case(8'hBB, 8'h00, 1'b1, 8'h6E, 16'hA5C3, 8'hFE, 8'hBB, 3'b100, 16'hA5C3, 8'hFF);
        // Loads, carry set and clear, NOP and an unknown opcode
        add_case(8'h12, 8'h00, 1'b1, 8'hA9, 16'h0080, 8'h00, 8'h80, 3'b101, 16'h0000, 8'h00);
        add_case(8'h7F, 8'h01, 1'b0, 8'hA9, 16'h0000, 8'h00, 8'h00, 3'b010, 16'h0000, 8'h00);
        add_case(8'h34, 8'h56, 1'b0, 8'hA2, 16'h0000, 8'h00, 8'h34, 3'b010, 16'h0000, 8'h00);
        add_case(8'h01, 8'h80, 1'b0, 8'h38, 16'h0000, 8'h00, 8'h01, 3'b101, 16'h0000, 8'h00);
        add_case(8'h01, 8'h00, 1'b1, 8'h18, 16'h0000, 8'h00, 8'h01, 3'b010, 16'h0000, 8'h00);
        add_case(8'h9C, 8'h7E, 1'b1, 8'hEA, 16'h0000, 8'h00, 8'h9C, 3'b001, 16'h0000, 8'h00);
        add_case(8'hC0, 8'h00, 1'b0, 8'hFF, 16'h0000, 8'h00, 8'hC0, 3'b010, 16'h0000, 8'h00);

        #1;
        arst_n = 1'b0; // Falling edge starts the asynchronous reset
        repeat (10) next_cycle();
        check_value("acc after reset", 16'(acc), 16'h0000);
        check_value("x after reset", 16'(x), 16'h0000);
        check_value("flags after reset", 16'({flag_n, flag_z, flag_c}), 16'h0000);
        arst_n  = 1'b1;
        reached = 1'b1;

        // Second round repeats the table under random rdy stalls
        for (round = 0; round < 2 && reached; round++) begin
            stalls_on = (round == 1);
            for (i = 0; i < tab_op.size() && reached; i++) begin
                err_before  = errors;
                writes_seen = 0;
                load_case(i);
                wait_for_syncs(sync_seen + 5, i, reached); // Five fetches up to the NOP
                if (reached) begin
                    check_case(i);
                    cases_run = cases_run + 1;
                    $display("case %2d opcode %02h stalls %0d: %0s", i, tab_op[i], round,
                             (errors == err_before) ? "match" : "mismatch");
                end
            end
        end

        $display("%0d cases run, %0d checks, %0d errors", cases_run, checks, errors);
        if (reached && errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
